/* rram_ctrl_top.f */
hw/rram_isa_pkg.sv
hw/xbar_pkg.sv
hw/xbar_cmd_if.sv
hw/instr_sequencer.sv
hw/row_driver.sv
hw/column_driver.sv
hw/adc_readout.sv
hw/rram_ctrl_top.sv
tb/rram_ctrl_asserts.sv
tb/tb_rram_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RRAM controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rram_ctrl \
    -f rram_ctrl_top.f \
    -o sim_rram_ctrl

./obj_dir/sim_rram_ctrl | tee sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
else
    exit 1
fi

/* tb/tb_rram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rram_ctrl;
    import rram_isa_pkg::*;
    import xbar_pkg::*;

    localparam int NUM_WL    = 64;
    localparam int NUM_SL    = 64;
    localparam int NUM_ADC   = 4;
    localparam int DATA_W    = 16;
    localparam int WP        = 4;                   // Program pulses per polarity
    localparam int CPA       = NUM_SL / NUM_ADC;
    localparam int CLK_NS    = 8;
    localparam int MAX_INSTR = 24;
    localparam int WORST_CYC = 4 * 8 * (1 + 2 * WP) + 40;   // Longest store, stalls included

    logic                        CLK;
    logic                        RESET_ACC;
    logic [INSTR_WORD_W-1:0]     instr_dout;
    logic                        instr_empty, instr_pop_n;
    logic [DATA_W-1:0]           data_dout;
    logic                        data_empty, data_pop_n;
    logic                        out_full, out_push_n;
    logic [DATA_W-1:0]           out_din;
    logic [NUM_WL-1:0]           wl_sel;
    logic                        wl_bias_sel, sl_bias_sel;
    logic [NUM_SL*3-1:0]         bl_sel, sl_sel;
    logic [NUM_SL-1:0]           sl_mux_sel;
    logic [2:0]                  bl_bias_sel;
    logic [NUM_ADC*ADC_THERM_W-1:0] adc_therm;

    logic [INSTR_WORD_W-1:0] instr_q [$];   // FIFO models
    logic [DATA_W-1:0]       data_q [$];
    logic [DATA_W-1:0]       exp_out_q [$];  // Expected pushes in order
    logic [23:0]             store_q [$];    // {row, group, weight} per store word
    logic [15:0]             exp_acc [NUM_ADC];
    logic [3:0]              cur_code;
    logic [5:0]              st_row;
    logic [1:0]              st_grp;
    logic [15:0]             st_w;
    int prog_cnt, prog_total, exp_prog, errors, checks, pop_cnt, loaded_cnt, stall_pct;

    rram_ctrl_top #(.NUM_WL(NUM_WL), .NUM_SL(NUM_SL), .NUM_ADC(NUM_ADC),
                    .DATA_W(DATA_W), .WRITE_PULSES(WP)) DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_NS / 2) CLK = ~CLK;
    end

    function automatic logic [3:0] col_hash(int c);
        return 4'((c * 7) ^ (c >> 2));   // Per-column cell value
    endfunction

    // ADC model, hash of muxed column plus active word lines
    always_comb begin
        int ones;
        int col;
        logic [3:0] code;
        ones = 0;
        for (int i = 0; i < NUM_WL; i++) ones += int'(wl_sel[i]);
        for (int a = 0; a < NUM_ADC; a++) begin
            col = -1;
            for (int j = 0; j < CPA; j++)
                if (sl_mux_sel[a * CPA + j] && col < 0) col = a * CPA + j;
            code = (col < 0) ? 4'd0 : 4'(int'(col_hash(col)) + ones);
            for (int b = 0; b < ADC_THERM_W; b++)
                adc_therm[a * ADC_THERM_W + b] = (b < int'(code));
        end
    end

    task automatic value_error(string name, logic [63:0] exp, logic [63:0] got);
        $display("** Error %s: expected %h, got %h", name, exp, got);
        errors++;
    endtask

    task automatic note_failure(string msg);
        $display("%s", msg);
        errors++;
    endtask

    // Own failures plus failed bound properties
    function automatic int error_total();
        return errors + DUT.u_asserts.fail_cnt;
    endfunction

    // FIFO levels and random stalls
    always @(negedge CLK) begin
        instr_empty = (instr_q.size() == 0) || ($urandom_range(99) < stall_pct);
        instr_dout  = (instr_q.size() != 0) ? instr_q[0] : '0;
        data_empty  = (data_q.size() == 0) || ($urandom_range(99) < stall_pct);
        data_dout   = (data_q.size() != 0) ? data_q[0] : '0;
        out_full    = ($urandom_range(99) < stall_pct);
    end

    task automatic check_program();
        logic [2:0] exp_bl;
        logic [2:0] exp_sl;
        logic       w;
        checks++;
        assert (wl_sel == (64'd1 << st_row))
            else value_error("wl_sel", 64'd1 << st_row, wl_sel);
        for (int c = 0; c < NUM_SL; c++) begin
            w      = st_w[c % DATA_W];
            exp_bl = (c / DATA_W != int'(st_grp)) ? DRV_REF
                     : (prog_cnt >= WP) ? {1'b0, w, ~w} : {1'b0, ~w, w};
            exp_sl = (c / DATA_W != int'(st_grp)) ? DRV_REF
                     : (prog_cnt >= WP) ? {1'b0, ~w, w} : {1'b0, w, ~w};
            assert (bl_sel[3 * c +: 3] == exp_bl)
                else value_error($sformatf("bl_sel[%0d]", c), exp_bl, bl_sel[3 * c +: 3]);
            assert (sl_sel[3 * c +: 3] == exp_sl)
                else value_error($sformatf("sl_sel[%0d]", c), exp_sl, sl_sel[3 * c +: 3]);
        end
    endtask

    // Pops, pushes and program cycles seen at the clock edge
    always @(posedge CLK) begin
        if (!RESET_ACC) begin
            if (!instr_pop_n && instr_q.size() != 0) begin
                cur_code = instr_dout[INSTR_WORD_W-1 -: INSTR_W];
                pop_cnt++;
                void'(instr_q.pop_front());
            end
            if (!data_pop_n && data_q.size() != 0) begin
                if (cur_code == 4'd4 && store_q.size() != 0) begin
                    {st_row, st_grp, st_w} = store_q.pop_front();
                    prog_cnt = 0;
                end
                void'(data_q.pop_front());
            end
            if (!out_push_n) begin
                checks++;
                if (exp_out_q.size() == 0) note_failure("output push with no word expected");
                else begin
                    assert (out_din == exp_out_q[0])
                        else value_error("out_din", exp_out_q[0], out_din);
                    void'(exp_out_q.pop_front());
                end
            end
            if (wl_bias_sel) begin
                check_program();
                prog_cnt++;
                prog_total++;
            end
        end
    end

    task automatic add_instr(logic [3:0] code, opcode_u op);
        instr_q.push_back({code, op});
        loaded_cnt++;
    endtask

    task automatic add_store(int row, int col_base, int burst);
        opcode_u op;
        logic [15:0] w;
        op = '0;
        op.access.burst    = 3'(burst);
        op.access.col_base = 3'(col_base);
        op.access.row_addr = 10'(row);
        add_instr(4'd4, op);
        exp_prog += (burst + 1) * 2 * WP;   // Two pulse trains per word
        for (int k = 0; k <= burst; k++) begin
            w = 16'($urandom);
            data_q.push_back(w);
            store_q.push_back({6'(row % NUM_WL), 2'((col_base + k) % 4), w});
        end
    endtask

    task automatic add_read(int row, int col_base, int burst);
        opcode_u op;
        logic [15:0] word;
        int col;
        op = '0;
        op.access.burst    = 3'(burst);
        op.access.col_base = 3'(col_base);
        op.access.row_addr = 10'(row);
        add_instr(4'd5, op);
        for (int k = 0; k <= burst; k++) begin
            for (int j = 0; j < 4; j++) begin
                col = 4 * ((col_base + k) % 16) + j;
                word[4 * j +: 4] = col_hash(col) + 4'd1;   // One word line active
            end
            exp_out_q.push_back(word);
        end
    endtask

    task automatic add_compute(int seg, int col_burst, bit clear);
        opcode_u op;
        op = '0;
        op.compute.row_seg   = 3'(seg);
        op.compute.col_burst = 4'(col_burst);
        op.compute.acc_clear = clear;
        add_instr(4'd7, op);
        data_q.push_back(16'($urandom));
        if (clear) for (int a = 0; a < NUM_ADC; a++) exp_acc[a] = '0;
        // Ternary pairs keep 16 lines active, so the count vanishes mod 16
        for (int a = 0; a < NUM_ADC; a++)
            for (int c = 0; c <= col_burst; c++) exp_acc[a] += 16'(col_hash(a * CPA + c));
    endtask

    task automatic add_phd_read();
        opcode_u op;
        op = '0;
        op.compute.rd_en = 1'b1;
        add_instr(4'd7, op);
        for (int a = 0; a < NUM_ADC; a++) exp_out_q.push_back(exp_acc[a]);
    endtask

    // Trailing unknown code marks the end of the previous instruction
    task automatic run_queued(string name);
        int start_err;
        start_err = error_total();
        add_instr(4'd0, '0);
        while (instr_q.size() != 0) @(posedge CLK);
        repeat (2) @(posedge CLK);
        if (exp_out_q.size() != 0)
            note_failure($sformatf("%s: %0d output words missing", name, exp_out_q.size()));
        if (data_q.size() != 0)
            note_failure($sformatf("%s: data words left unpopped", name));
        if (pop_cnt != loaded_cnt)
            note_failure($sformatf("%s: %0d pops for %0d instructions",
                                   name, pop_cnt, loaded_cnt));
        if (prog_total != exp_prog)
            note_failure($sformatf("%s: %0d program cycles where %0d were due",
                                   name, prog_total, exp_prog));
        $display("test %-8s done, %0d errors", name, error_total() - start_err);
    endtask

    initial begin
        #(CLK_NS * (10 + MAX_INSTR * WORST_CYC));
        $display("timeout: instructions still pending after the watchdog limit");
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(40603));
        RESET_ACC   = 1'b1;
        instr_empty = 1'b1;
        instr_dout  = '0;
        data_empty  = 1'b1;
        data_dout   = '0;
        out_full    = 1'b0;
        stall_pct   = 0;
        for (int a = 0; a < NUM_ADC; a++) exp_acc[a] = '0;
        repeat (4) @(posedge CLK);
        checks++;
        assert (instr_pop_n && data_pop_n && out_push_n && wl_sel == '0
                && bl_sel == {NUM_SL{DRV_REF}} && sl_sel == {NUM_SL{DRV_REF}})
            else note_failure("outputs not idle during reset");
        $display("test %-8s done, %0d errors", "reset", error_total());
        @(negedge CLK) RESET_ACC = 1'b0;
        stall_pct = 25;
        add_store(70, 1, 3);   // Row wraps to 6
        add_store(13, 3, 1);
        run_queued("store");
        add_read(5, 7, 7);     // Highest base and longest burst, up to column 59
        add_read(40, 2, 3);
        run_queued("read");
        add_compute(1, 15, 1'b1);
        add_compute(0, 5, 1'b0);
        add_phd_read();
        run_queued("compute");
        add_instr(4'd9, 16'hbeef);
        add_instr(4'd2, 16'h1234);
        run_queued("unknown");
        errors = error_total();
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rram_ctrl_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rram_ctrl_asserts #(
    parameter int NUM_WL = xbar_pkg::DEF_NUM_WL,
    parameter int NUM_SL = xbar_pkg::DEF_NUM_SL
) (
    input wire                CLK,
    input wire                RESET_ACC,
    input wire                instr_empty,
    input wire                instr_pop_n,
    input wire                data_empty,
    input wire                data_pop_n,
    input wire                out_full,
    input wire                out_push_n,
    input wire [NUM_WL-1:0]   wl_sel,
    input wire                wl_bias_sel,
    input wire [NUM_SL*3-1:0] bl_sel,
    input wire [NUM_SL*3-1:0] sl_sel,
    input wire [2:0]          bl_bias_sel,
    input wire                sl_bias_sel
);
    import xbar_pkg::*;

    localparam logic [NUM_SL*3-1:0] ALL_REF = {NUM_SL{DRV_REF}};   // Idle column drive

    int fail_cnt = 0;   // Failed properties so far

    // Quiet array and strobes once reset has been sampled
    assert property (@(posedge CLK) RESET_ACC |=>
        (instr_pop_n && data_pop_n && out_push_n && wl_sel == '0
         && bl_sel == ALL_REF && sl_sel == ALL_REF))
        else begin
            $error("outputs not idle after reset");
            fail_cnt++;
        end

    // FIFO strobes only against a ready FIFO
    assert property (@(posedge CLK) disable iff (RESET_ACC) !(!instr_pop_n && instr_empty))
        else begin
            $error("instruction pop while empty");
            fail_cnt++;
        end
    assert property (@(posedge CLK) disable iff (RESET_ACC) !(!data_pop_n && data_empty))
        else begin
            $error("data pop while empty");
            fail_cnt++;
        end
    assert property (@(posedge CLK) disable iff (RESET_ACC) !(!out_push_n && out_full))
        else begin
            $error("output push while full");
            fail_cnt++;
        end

    // Column write bias goes with the row write bias, read bias otherwise
    assert property (@(posedge CLK) disable iff (RESET_ACC)
        (bl_bias_sel == {3{wl_bias_sel}} && sl_bias_sel == wl_bias_sel))
        else begin
            $error("column bias selects disagree with the word-line bias");
            fail_cnt++;
        end

endmodule

bind rram_ctrl_top rram_ctrl_asserts #(.NUM_WL(NUM_WL), .NUM_SL(NUM_SL)) u_asserts (
    .CLK(CLK), .RESET_ACC(RESET_ACC),
    .instr_empty(instr_empty), .instr_pop_n(instr_pop_n),
    .data_empty(data_empty), .data_pop_n(data_pop_n),
    .out_full(out_full), .out_push_n(out_push_n),
    .wl_sel(wl_sel), .wl_bias_sel(wl_bias_sel), .bl_sel(bl_sel), .sl_sel(sl_sel),
    .bl_bias_sel(bl_bias_sel), .sl_bias_sel(sl_bias_sel)
);

`default_nettype wire

/* hw/rram_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rram_ctrl_top #(
    parameter int NUM_WL       = xbar_pkg::DEF_NUM_WL,
    parameter int NUM_SL       = xbar_pkg::DEF_NUM_SL,
    parameter int NUM_ADC      = xbar_pkg::DEF_NUM_ADC,
    parameter int DATA_W       = xbar_pkg::DEF_DATA_W,
    parameter int WRITE_PULSES = xbar_pkg::DEF_WRITE_PULSES
) (
    input  logic                                     CLK,
    input  logic                                     RESET_ACC,
    input  logic [rram_isa_pkg::INSTR_WORD_W-1:0]    instr_dout,   // Instruction FIFO
    input  logic                                     instr_empty,
    output logic                                     instr_pop_n,
    input  logic [DATA_W-1:0]                        data_dout,    // Input data FIFO
    input  logic                                     data_empty,
    output logic                                     data_pop_n,
    input  logic                                     out_full,     // Output FIFO
    output logic                                     out_push_n,
    output logic [DATA_W-1:0]                        out_din,
    output logic [NUM_WL-1:0]                        wl_sel,       // Array drive
    output logic                                     wl_bias_sel,
    output logic [NUM_SL*3-1:0]                      bl_sel,
    output logic [NUM_SL*3-1:0]                      sl_sel,
    output logic [NUM_SL-1:0]                        sl_mux_sel,
    output logic [2:0]                               bl_bias_sel,
    output logic                                     sl_bias_sel,
    input  logic [NUM_ADC*xbar_pkg::ADC_THERM_W-1:0] adc_therm
);

    logic acc_clear_pulse;   // Instruction-level clear

    xbar_cmd_if #(.NUM_WL(NUM_WL), .NUM_SL(NUM_SL), .DATA_W(DATA_W)) xcmd ();

    instr_sequencer #(
        .NUM_WL(NUM_WL), .NUM_SL(NUM_SL), .NUM_ADC(NUM_ADC),
        .DATA_W(DATA_W), .WRITE_PULSES(WRITE_PULSES)
    ) u_seq (
        .CLK(CLK), .RESET_ACC(RESET_ACC),
        .instr_dout(instr_dout), .instr_empty(instr_empty), .instr_pop_n(instr_pop_n),
        .data_dout(data_dout), .data_empty(data_empty), .data_pop_n(data_pop_n),
        .out_full(out_full), .out_push_n(out_push_n),
        .acc_clear_pulse(acc_clear_pulse), .cmd(xcmd)
    );

    row_driver #(.NUM_WL(NUM_WL), .DATA_W(DATA_W)) u_row (
        .CLK(CLK), .RESET_ACC(RESET_ACC), .cmd(xcmd),
        .wl_sel(wl_sel), .wl_bias_sel(wl_bias_sel)
    );

    column_driver #(.NUM_SL(NUM_SL), .NUM_ADC(NUM_ADC), .DATA_W(DATA_W)) u_col (
        .CLK(CLK), .RESET_ACC(RESET_ACC), .cmd(xcmd),
        .bl_sel(bl_sel), .sl_sel(sl_sel), .sl_mux_sel(sl_mux_sel),
        .bl_bias_sel(bl_bias_sel), .sl_bias_sel(sl_bias_sel)
    );

    adc_readout #(.NUM_SL(NUM_SL), .NUM_ADC(NUM_ADC), .DATA_W(DATA_W)) u_adc (
        .CLK(CLK), .RESET_ACC(RESET_ACC), .cmd(xcmd),
        .acc_clear_pulse(acc_clear_pulse), .adc_therm(adc_therm), .out_din(out_din)
    );

endmodule

`default_nettype wire

/* hw/adc_readout.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_readout #(
    parameter int NUM_SL  = xbar_pkg::DEF_NUM_SL,
    parameter int NUM_ADC = xbar_pkg::DEF_NUM_ADC,
    parameter int DATA_W  = xbar_pkg::DEF_DATA_W
) (
    input  logic                                     CLK,
    input  logic                                     RESET_ACC,
    xbar_cmd_if.slave                                cmd,
    input  logic                                     acc_clear_pulse,
    input  logic [NUM_ADC*xbar_pkg::ADC_THERM_W-1:0] adc_therm,
    output logic [DATA_W-1:0]                        out_din
);
    import xbar_pkg::*;

    localparam int CPA       = NUM_SL / NUM_ADC;
    localparam int CODES     = DATA_W / ADC_W;     // Codes per output word
    localparam int OUT_WORDS = NUM_SL / CODES;

    logic [ADC_W-1:0]     lane_code [NUM_ADC];
    logic [ADC_W-1:0]     code_q    [NUM_SL];      // One code per column
    logic [PHD_ACC_W-1:0] acc_q     [NUM_ADC];     // Partial HD per class

    // Ones count of each thermometer word
    always_comb begin
        for (int a = 0; a < NUM_ADC; a++) begin
            lane_code[a] = '0;
            for (int b = 0; b < ADC_THERM_W; b++) begin
                lane_code[a] = lane_code[a] + ADC_W'(adc_therm[a * ADC_THERM_W + b]);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            for (int c = 0; c < NUM_SL; c++) code_q[c] <= '0;
            for (int a = 0; a < NUM_ADC; a++) acc_q[a] <= '0;
        end else begin
            for (int a = 0; a < NUM_ADC; a++) begin
                if (cmd.cmd == CMD_READ_CELL)
                    code_q[a * CPA + (int'(cmd.col_offset) % CPA)] <= lane_code[a];
                if (acc_clear_pulse) acc_q[a] <= '0;
                else if (cmd.cmd == CMD_COMPUTE) acc_q[a] <= acc_q[a] + PHD_ACC_W'(lane_code[a]);
            end
        end
    end

    always_comb begin
        out_din = '0;
        case (cmd.cmd)
            CMD_READ_ADC_OUT: begin
                for (int j = 0; j < CODES; j++) begin   // Lowest column in low nibble
                    out_din[j * ADC_W +: ADC_W] =
                        code_q[(int'(cmd.word_idx) % OUT_WORDS) * CODES + j];
                end
            end
            CMD_READ_PHD: out_din = DATA_W'(acc_q[int'(cmd.word_idx) % NUM_ADC]);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/column_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module column_driver #(
    parameter int NUM_SL  = xbar_pkg::DEF_NUM_SL,
    parameter int NUM_ADC = xbar_pkg::DEF_NUM_ADC,
    parameter int DATA_W  = xbar_pkg::DEF_DATA_W
) (
    input  logic                CLK,
    input  logic                RESET_ACC,
    xbar_cmd_if.slave           cmd,
    output logic [NUM_SL*3-1:0] bl_sel,       // Column i at [3i+:3]
    output logic [NUM_SL*3-1:0] sl_sel,
    output logic [NUM_SL-1:0]   sl_mux_sel,   // SL to ADC mux
    output logic [2:0]          bl_bias_sel,
    output logic                sl_bias_sel
);
    import xbar_pkg::*;

    localparam int CPA    = NUM_SL / NUM_ADC;
    localparam int GROUPS = NUM_SL / DATA_W;

    logic [NUM_SL-1:0] weight_q;
    logic [NUM_SL-1:0] colsel_q;   // Columns of the loaded group

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            weight_q <= '0;
            colsel_q <= '0;
        end else if (cmd.cmd == CMD_WRITE_WEIGHTS) begin
            colsel_q <= '0;
            colsel_q[(int'(cmd.word_idx) % GROUPS) * DATA_W +: DATA_W] <= '1;
            weight_q[(int'(cmd.word_idx) % GROUPS) * DATA_W +: DATA_W] <= cmd.data;
        end
    end

    always_comb begin
        int col;
        bl_bias_sel = 3'b000;   // Read bias
        sl_bias_sel = 1'b0;
        sl_mux_sel  = '0;
        for (int i = 0; i < NUM_SL; i++) begin
            bl_sel[3 * i +: 3] = DRV_REF;
            sl_sel[3 * i +: 3] = DRV_REF;
        end
        case (cmd.cmd)
            CMD_PROGRAM: begin
                for (int i = 0; i < NUM_SL; i++) begin
                    if (colsel_q[i] && !cmd.col_pol) begin
                        bl_sel[3 * i +: 3] = {1'b0, ~weight_q[i], weight_q[i]};
                        sl_sel[3 * i +: 3] = {1'b0, weight_q[i], ~weight_q[i]};
                    end else if (colsel_q[i]) begin
                        bl_sel[3 * i +: 3] = {1'b0, weight_q[i], ~weight_q[i]};   // Other device
                        sl_sel[3 * i +: 3] = {1'b0, ~weight_q[i], weight_q[i]};
                    end
                end
                bl_bias_sel = 3'b111;   // Write bias on plus, minus, ref
                sl_bias_sel = 1'b1;
            end
            CMD_READ_CELL, CMD_COMPUTE: begin
                // Same offset in every lane
                for (int a = 0; a < NUM_ADC; a++) begin
                    col = a * CPA + (int'(cmd.col_offset) % CPA);
                    bl_sel[3 * col +: 3] = DRV_READ_BL;
                    sl_sel[3 * col +: 3] = DRV_FLOAT;      // SL charges the sense cap
                    sl_mux_sel[col]      = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/row_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module row_driver #(
    parameter int NUM_WL = xbar_pkg::DEF_NUM_WL,
    parameter int DATA_W = xbar_pkg::DEF_DATA_W
) (
    input  logic              CLK,
    input  logic              RESET_ACC,
    xbar_cmd_if.slave         cmd,
    output logic [NUM_WL-1:0] wl_sel,
    output logic              wl_bias_sel   // High selects write bias
);
    import xbar_pkg::*;

    localparam int SEG_LINES = 2 * DATA_W;  // Two lines per input bit

    logic [NUM_WL-1:0] in_q;                // Ternary input pairs

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            in_q <= '0;
        end else if (cmd.cmd == CMD_WRITE_INPUTS) begin
            for (int i = 0; i < DATA_W; i++) begin
                in_q[int'(cmd.row_seg) * SEG_LINES + 2 * i]     <= cmd.data[i];
                in_q[int'(cmd.row_seg) * SEG_LINES + 2 * i + 1] <= ~cmd.data[i];   // Complement line
            end
        end
    end

    always_comb begin
        wl_sel      = '0;
        wl_bias_sel = 1'b0;
        case (cmd.cmd)
            CMD_PROGRAM: begin
                wl_sel[cmd.row_idx] = 1'b1;
                wl_bias_sel         = 1'b1;
            end
            CMD_READ_CELL: wl_sel[cmd.row_idx] = 1'b1;
            CMD_COMPUTE: begin
                // Whole stored segment at once
                wl_sel[int'(cmd.row_seg) * SEG_LINES +: SEG_LINES] =
                    in_q[int'(cmd.row_seg) * SEG_LINES +: SEG_LINES];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/instr_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer #(
    parameter int NUM_WL       = xbar_pkg::DEF_NUM_WL,
    parameter int NUM_SL       = xbar_pkg::DEF_NUM_SL,
    parameter int NUM_ADC      = xbar_pkg::DEF_NUM_ADC,
    parameter int DATA_W       = xbar_pkg::DEF_DATA_W,
    parameter int WRITE_PULSES = xbar_pkg::DEF_WRITE_PULSES
) (
    input  logic                                  CLK,
    input  logic                                  RESET_ACC,
    input  logic [rram_isa_pkg::INSTR_WORD_W-1:0] instr_dout,
    input  logic                                  instr_empty,
    output logic                                  instr_pop_n,
    input  logic [DATA_W-1:0]                     data_dout,
    input  logic                                  data_empty,
    output logic                                  data_pop_n,
    input  logic                                  out_full,
    output logic                                  out_push_n,
    output logic                                  acc_clear_pulse,
    xbar_cmd_if.master                            cmd
);
    import rram_isa_pkg::*;
    import xbar_pkg::*;

    localparam int CPA       = NUM_SL / NUM_ADC;          // Columns per ADC
    localparam int GROUPS    = NUM_SL / DATA_W;           // Weight groups
    localparam int OUT_WORDS = NUM_SL * ADC_W / DATA_W;   // Code words per row
    localparam int ROW_W     = $clog2(NUM_WL);
    localparam int SEG_W     = $clog2(NUM_WL / (2 * DATA_W));
    localparam int COL_W     = $clog2(NUM_SL);
    localparam int CNT_W     = $clog2(2 * WRITE_PULSES + CPA + 1);
    localparam int BEAT_W    = ($clog2(NUM_ADC) > 3) ? $clog2(NUM_ADC) : 3;

    typedef enum logic [2:0] {
        S_INIT,         // One quiet cycle after reset
        S_IDLE,
        S_STORE,
        S_READ_CELLS,
        S_READ_OUT,
        S_LOAD_INPUTS,
        S_COMPUTE,
        S_PHD_OUT
    } state_t;

    state_t            state;
    opcode_u           op_q;
    logic [CNT_W-1:0]  cnt;       // Cycle inside a phase
    logic [BEAT_W-1:0] beat;      // Burst word or class
    instr_code_t       new_code;
    opcode_u           new_op;
    logic              instr_pop;
    logic              data_pop;
    logic              out_push;

    assign new_code = instr_code_t'(instr_dout[INSTR_WORD_W-1 -: INSTR_W]);
    assign new_op   = instr_dout[OPCODE_W-1:0];

    // FWFT strobes, word valid in the strobe cycle
    assign instr_pop = (state == S_IDLE) && !instr_empty;
    assign data_pop  = ((state == S_STORE && cnt == '0) || state == S_LOAD_INPUTS) && !data_empty;
    assign out_push  = (state == S_READ_OUT || state == S_PHD_OUT) && !out_full;

    assign instr_pop_n = !instr_pop;
    assign data_pop_n  = !data_pop;
    assign out_push_n  = !out_push;

    assign acc_clear_pulse = instr_pop && (new_code == INSTR_HAM_SEG_COMPUTE)
                             && new_op.compute.acc_clear && !new_op.compute.rd_en;

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            state <= S_INIT;
            op_q  <= '0;
            cnt   <= '0;
            beat  <= '0;
        end else begin
            case (state)
                S_INIT: state <= S_IDLE;
                S_IDLE: begin
                    cnt  <= '0;
                    beat <= '0;
                    if (instr_pop) begin
                        op_q <= new_op;
                        case (new_code)
                            INSTR_STORE_RRAM:      state <= S_STORE;
                            INSTR_READ_RRAM:       state <= S_READ_CELLS;
                            INSTR_HAM_SEG_COMPUTE: begin
                                state <= new_op.compute.rd_en ? S_PHD_OUT : S_LOAD_INPUTS;
                            end
                            default:               state <= S_IDLE;   // Unknown code dropped
                        endcase
                    end
                end
                S_STORE: begin
                    if (cnt == '0) begin
                        if (data_pop) cnt <= cnt + 1'b1;    // Load waits for data
                    end else if (cnt == CNT_W'(2 * WRITE_PULSES)) begin
                        cnt <= '0;                          // Both polarities done
                        if (beat == BEAT_W'(op_q.access.burst)) state <= S_IDLE;
                        else beat <= beat + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_READ_CELLS: begin
                    if (cnt == CNT_W'(CPA - 1)) begin
                        cnt   <= '0;
                        state <= S_READ_OUT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_READ_OUT: begin
                    if (out_push) begin
                        if (beat == BEAT_W'(op_q.access.burst)) state <= S_IDLE;
                        else beat <= beat + 1'b1;
                    end
                end
                S_LOAD_INPUTS: if (data_pop) state <= S_COMPUTE;
                S_COMPUTE: begin
                    if (cnt == CNT_W'(op_q.compute.col_burst)) state <= S_IDLE;
                    else cnt <= cnt + 1'b1;
                end
                S_PHD_OUT: begin
                    if (out_push) begin
                        if (beat == BEAT_W'(NUM_ADC - 1)) state <= S_IDLE;
                        else beat <= beat + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Local command, one level per cycle
    always_comb begin
        cmd.cmd        = CMD_NOP;
        cmd.row_idx    = op_q.access.row_addr[ROW_W-1:0];   // Row mod NUM_WL
        cmd.row_seg    = op_q.compute.row_seg[SEG_W-1:0];
        cmd.col_pol    = (cnt > CNT_W'(WRITE_PULSES));      // Second pulse train
        cmd.col_offset = COL_W'(cnt);
        cmd.word_idx   = '0;
        cmd.data       = data_dout;
        case (state)
            S_STORE: begin
                if (cnt != '0) cmd.cmd = CMD_PROGRAM;
                else if (!data_empty) cmd.cmd = CMD_WRITE_WEIGHTS;
                cmd.word_idx = COL_W'((int'(op_q.access.col_base) + int'(beat)) % GROUPS);
            end
            S_READ_CELLS: cmd.cmd = CMD_READ_CELL;
            S_READ_OUT: begin
                cmd.cmd      = CMD_READ_ADC_OUT;   // Word stays up while full
                cmd.word_idx = COL_W'((int'(op_q.access.col_base) + int'(beat)) % OUT_WORDS);
            end
            S_LOAD_INPUTS: if (!data_empty) cmd.cmd = CMD_WRITE_INPUTS;
            S_COMPUTE:     cmd.cmd = CMD_COMPUTE;
            S_PHD_OUT: begin
                cmd.cmd      = CMD_READ_PHD;
                cmd.word_idx = COL_W'(beat);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/xbar_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface xbar_cmd_if #(
    parameter int NUM_WL = xbar_pkg::DEF_NUM_WL,
    parameter int NUM_SL = xbar_pkg::DEF_NUM_SL,
    parameter int DATA_W = xbar_pkg::DEF_DATA_W
);
    import xbar_pkg::*;

    xbar_cmd_t                            cmd;
    logic [$clog2(NUM_WL)-1:0]            row_idx;     // Single row for program/read
    logic [$clog2(NUM_WL/(2*DATA_W))-1:0] row_seg;     // Input segment
    logic                                 col_pol;     // Differential program phase
    logic [$clog2(NUM_SL)-1:0]            col_offset;  // Column inside each ADC lane
    logic [$clog2(NUM_SL)-1:0]            word_idx;    // Group, output word or class
    logic [DATA_W-1:0]                    data;        // Popped data word

    modport master (output cmd, row_idx, row_seg, col_pol, col_offset, word_idx, data);
    modport slave  (input  cmd, row_idx, row_seg, col_pol, col_offset, word_idx, data);

endinterface

`default_nettype wire

/* hw/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

    // Local array commands, one per cycle
    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_WRITE_WEIGHTS,
        CMD_PROGRAM,
        CMD_READ_CELL,
        CMD_READ_ADC_OUT,
        CMD_WRITE_INPUTS,
        CMD_COMPUTE,
        CMD_READ_PHD
    } xbar_cmd_t;

    // BL/SL drive codes {ref, minus, plus}
    localparam logic [2:0] DRV_REF     = 3'b100;
    localparam logic [2:0] DRV_READ_BL = 3'b001;
    localparam logic [2:0] DRV_FLOAT   = 3'b000;

    localparam int ADC_W       = 4;
    localparam int ADC_THERM_W = 15;
    localparam int PHD_ACC_W   = 16;

    // Simulation-sized array
    localparam int DEF_NUM_WL       = 64;
    localparam int DEF_NUM_SL       = 64;
    localparam int DEF_NUM_ADC      = 4;
    localparam int DEF_DATA_W       = 16;
    localparam int DEF_WRITE_PULSES = 4;

endpackage

`default_nettype wire

/* hw/rram_isa_pkg.sv */
`default_nettype none

package rram_isa_pkg;

    localparam int INSTR_W      = 4;
    localparam int OPCODE_W     = 16;
    localparam int INSTR_WORD_W = INSTR_W + OPCODE_W;   // Code on top, opcode below

    // Instruction codes; anything else is popped and dropped
    typedef enum logic [INSTR_W-1:0] {
        INSTR_STORE_RRAM      = 4'd4,
        INSTR_READ_RRAM       = 4'd5,
        INSTR_HAM_SEG_COMPUTE = 4'd7
    } instr_code_t;

    // Row access view for STORE_RRAM and READ_RRAM
    typedef struct packed {
        logic [2:0] burst;      // Words minus one
        logic [2:0] col_base;   // First column group
        logic [9:0] row_addr;
    } access_op_t;

    // Segment compute view for HAM_SEG_COMPUTE
    typedef struct packed {
        logic [6:0] rsvd;
        logic       rd_en;      // Read accumulators instead of computing
        logic       acc_clear;  // Zero accumulators at pop
        logic [3:0] col_burst;  // Column offsets minus one
        logic [2:0] row_seg;
    } compute_op_t;

    typedef union packed {
        access_op_t  access;
        compute_op_t compute;
    } opcode_u;

endpackage

`default_nettype wire
